// ==== include/ptw_consts.svh ====
// Queue and buffer depths, field widths and the walk level encoding
`ifndef PTW_CONSTS_SVH
`define PTW_CONSTS_SVH

// ==================================================
// Storage depths
// ==================================================

// Miss queue entries, which also bounds the reads in flight
`define PTW_MISSQ_SIZE 4
// Reply slots in the translation buffer
`define PTW_TRANBUF_SIZE 4
// Width of a free slot count, which runs from zero up to the buffer depth
`define PTW_BFREE_W 3

// ==================================================
// Field widths and level codes
// ==================================================

`define PTW_QE_W 2
`define PTW_ROB_W 5
`define PTW_ASID_W 8
// Levels step 1, 0 and then land on this code once the walk is over
`define PTW_LVL_DONE 2'd3

`endif

// ==== source/ptw_pkg.sv ====
// Page table entry views, miss queue entry and reply slot types
`include "ptw_consts.svh"

package ptw_pkg;

	// ==================================================
	// Page table entry, one 32-bit word
	// ==================================================

	// Pointer view. The leaf bit is clear and frame names the next table
	typedef struct packed {
		logic [19:0] frame;
		logic [9:0] rsvd;
		logic leaf;
		logic v;
	} pte_ptr_t;

	// Leaf view. The leaf bit is set and ppn is the translated frame
	typedef struct packed {
		logic [19:0] ppn;
		logic [5:0] rsvd;
		logic [3:0] flags;
		logic leaf;
		logic v;
	} pte_leaf_t;

	// The v and leaf bits sit at the same place in both views, so either view decodes them
	typedef union packed {
		pte_ptr_t ptr;
		pte_leaf_t leaf;
	} pte_u;

	// One outstanding miss. The fl bit marks an entry flushed while its read was out
	typedef struct packed {
		logic v;
		logic c;
		logic o;
		logic bc;
		logic fl;
		logic [1:0] lvl;
		logic [`PTW_ASID_W-1:0] asid;
		logic [`PTW_ROB_W-1:0] id;
		logic [1:0] qn;
		logic [31:0] adr;
		logic [31:0] tadr;
	} missq_entry_t;

	// A memory reply waiting for the miss queue, tagged with its owner
	typedef struct packed {
		logic v;
		logic [`PTW_QE_W-1:0] stk;
		pte_u pte;
	} tranbuf_entry_t;

endpackage

// ==== source/ptw_if.sv ====
// Walk request interface and translation reply interface with their modports
`timescale 1ns/1ps
`include "ptw_consts.svh"

// ==================================================
// Walk request from the miss queue to the walker
// ==================================================

// The request is a level that holds until the walker accepts it with issued
interface walk_if;
	logic req;
	logic [`PTW_QE_W-1:0] qe;
	logic [31:0] tadr;
	logic issued;

	modport source (output req, output qe, output tadr, input issued);
	modport sink (input req, input qe, input tadr, output issued);
endinterface

// ==================================================
// Reply path from the buffer to the miss queue
// ==================================================

// The buffer shows one full slot at a time and frees it on the edge where take is high
interface tran_if;
	logic sel_v;
	logic [`PTW_QE_W-1:0] stk;
	ptw_pkg::pte_u pte;
	logic take;

	modport source (output sel_v, output stk, output pte, input take);
	modport sink (input sel_v, input stk, input pte, output take);
endinterface

// ==== source/ptw_miss_queue.sv ====
// Miss queue with capture, duplicate check, commit and flush, walk selection and TLB update
`timescale 1ns/1ps
`include "ptw_consts.svh"

module ptw_miss_queue (
	input logic clk,
	input logic rst,
	input logic tlb_miss,
	input logic [31:0] tlb_miss_adr,
	input logic [`PTW_ASID_W-1:0] tlb_miss_asid,
	input logic [`PTW_ROB_W-1:0] tlb_miss_id,
	input logic [1:0] tlb_miss_qn,
	input logic [`PTW_ROB_W-1:0] commit0_id,
	input logic commit0_idv,
	input logic [`PTW_ROB_W-1:0] commit1_id,
	input logic commit1_idv,
	input logic flush_v,
	input logic [`PTW_ROB_W-1:0] flush_id,
	input logic [19:0] ptbr_frame,
	walk_if.source walk,
	tran_if.sink trn,
	output logic in_que,
	output logic full,
	output logic tlb_wr,
	output logic [`PTW_ASID_W-1:0] tlb_asid,
	output logic [19:0] tlb_vpn,
	output logic [19:0] tlb_ppn,
	output logic [3:0] tlb_flags,
	output logic tlb_super,
	output logic tlb_fault
);

	ptw_pkg::missq_entry_t q [`PTW_MISSQ_SIZE];

	logic dup;
	logic free_v;
	logic [`PTW_QE_W-1:0] free_qe;
	logic sel_v;
	logic [`PTW_QE_W-1:0] sel_qe;
	logic miss_commit;
	ptw_pkg::missq_entry_t te;
	logic kill;
	logic walk_end;

	// ==================================================
	// Search logic
	// ==================================================

	// Walk from the top down so the lowest matching index is the one left standing
	always_comb begin
		dup = 1'b0;
		free_v = 1'b0;
		free_qe = '0;
		sel_v = 1'b0;
		sel_qe = '0;
		full = 1'b1;
		for (int i = `PTW_MISSQ_SIZE - 1; i >= 0; i--) begin
			full &= q[i].v;
			// A duplicate is any live entry for the same asid and address
			if (q[i].v && q[i].asid == tlb_miss_asid && q[i].adr == tlb_miss_adr)
				dup = 1'b1;
			if (!q[i].v) begin
				free_v = 1'b1;
				free_qe = `PTW_QE_W'(i);
			end
			// Only committed entries waiting on their next step may walk
			if (q[i].v && q[i].c && q[i].bc) begin
				sel_v = 1'b1;
				sel_qe = `PTW_QE_W'(i);
			end
		end
	end

	// An instruction can commit in the same cycle that its miss shows up
	assign miss_commit = (commit0_idv && commit0_id == tlb_miss_id) ||
		(commit1_idv && commit1_id == tlb_miss_id);

	assign walk.req = sel_v;
	assign walk.qe = sel_qe;
	assign walk.tadr = q[sel_qe].tadr;

	// The owner of the offered reply, and whether its result is to be thrown away
	always_comb begin
		te = q[trn.stk];
		kill = te.fl || (flush_v && flush_id == te.id);
		// An invalid entry, a leaf, or anything read at level 0 ends the walk
		walk_end = kill || !trn.pte.ptr.v || trn.pte.ptr.leaf || te.lvl == 2'd0;
	end

	// Every reply is used in the cycle it is offered
	assign trn.take = trn.sel_v;

	// ==================================================
	// Entry state
	// ==================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `PTW_MISSQ_SIZE; i++) begin
				q[i].v <= 1'b0;
				q[i].c <= 1'b0;
				q[i].o <= 1'b0;
				q[i].bc <= 1'b0;
				q[i].fl <= 1'b0;
				q[i].lvl <= `PTW_LVL_DONE;
			end
			in_que <= 1'b0;
			tlb_wr <= 1'b0;
			tlb_fault <= 1'b0;
		end else begin
			// One pulse per duplicate, never two cycles running
			in_que <= tlb_miss && dup && !in_que;
			tlb_wr <= 1'b0;
			tlb_fault <= 1'b0;

			for (int i = 0; i < `PTW_MISSQ_SIZE; i++) begin
				if (q[i].v && ((commit0_idv && commit0_id == q[i].id) ||
					(commit1_idv && commit1_id == q[i].id)))
					q[i].c <= 1'b1;
				// A read already out keeps the entry alive until its reply returns
				if (q[i].v && flush_v && flush_id == q[i].id) begin
					if (q[i].o || (walk.issued && walk.qe == `PTW_QE_W'(i)))
						q[i].fl <= 1'b1;
					else
						q[i].v <= 1'b0;
				end
			end

			// The walker took the request, so wait for the reply
			if (walk.issued) begin
				q[walk.qe].bc <= 1'b0;
				q[walk.qe].o <= 1'b1;
			end

			if (trn.sel_v) begin
				if (walk_end) begin
					tlb_wr <= !kill && trn.pte.ptr.v;
					tlb_fault <= !kill && !trn.pte.ptr.v;
					tlb_asid <= te.asid;
					tlb_vpn <= te.adr[31:12];
					tlb_flags <= trn.pte.leaf.flags;
					tlb_super <= te.lvl == 2'd1;
					// A superpage maps 4 MiB so the low frame bits come from the address
					if (te.lvl == 2'd1)
						tlb_ppn <= {trn.pte.leaf.ppn[19:10], te.adr[21:12]};
					else
						tlb_ppn <= trn.pte.leaf.ppn;
					q[trn.stk].v <= 1'b0;
					q[trn.stk].c <= 1'b0;
					q[trn.stk].o <= 1'b0;
					q[trn.stk].bc <= 1'b0;
					q[trn.stk].fl <= 1'b0;
					q[trn.stk].lvl <= `PTW_LVL_DONE;
				end else begin
					// Pointer at level 1, index the second table with the next ten bits
					q[trn.stk].tadr <= {trn.pte.ptr.frame, te.adr[21:12], 2'b00};
					q[trn.stk].lvl <= 2'd0;
					q[trn.stk].o <= 1'b0;
					q[trn.stk].bc <= 1'b1;
				end
			end

			// New misses go to the lowest free entry, and are dropped when none is free
			if (tlb_miss && !dup && free_v) begin
				q[free_qe] <= '{
					v: 1'b1,
					c: miss_commit,
					o: 1'b0,
					bc: 1'b1,
					fl: 1'b0,
					lvl: 2'd1,
					asid: tlb_miss_asid,
					id: tlb_miss_id,
					qn: tlb_miss_qn,
					adr: tlb_miss_adr,
					tadr: {ptbr_frame, tlb_miss_adr[31:22], 2'b00}
				};
			end
		end
	end

endmodule

// ==== source/ptw_walker.sv ====
// Walker that turns a selected walk request into a tagged memory read
`timescale 1ns/1ps
`include "ptw_consts.svh"

module ptw_walker (
	input logic clk,
	input logic rst,
	walk_if.sink walk,
	input logic [`PTW_BFREE_W-1:0] buf_free,
	input logic mem_rvalid,
	output logic mem_rd,
	output logic [`PTW_QE_W-1:0] mem_tag,
	output logic [31:0] mem_adr
);

	// Reads sent to memory whose replies have not landed yet
	logic [`PTW_BFREE_W-1:0] inflight;

	// ==================================================
	// Issue control
	// ==================================================

	// Each read in flight has a buffer slot set aside for it.
	// A new read only goes out if one more slot is still free
	assign walk.issued = walk.req && (inflight < buf_free);

	always_ff @(posedge clk) begin
		if (rst) begin
			mem_rd <= 1'b0;
			inflight <= '0;
		end else begin
			mem_rd <= walk.issued;
			// A read and a reply in the same cycle leave the count alone
			case ({walk.issued, mem_rvalid})
				2'b10: inflight <= inflight + `PTW_BFREE_W'(1);
				2'b01: inflight <= inflight - `PTW_BFREE_W'(1);
				default: inflight <= inflight;
			endcase
		end
	end

	// ==================================================
	// Read payload
	// ==================================================

	// The tag is the queue index so the reply can find its owner
	always_ff @(posedge clk) begin
		if (walk.issued) begin
			mem_tag <= walk.qe;
			mem_adr <= walk.tadr;
		end
	end

endmodule

// ==== source/ptw_tran_buf.sv ====
// Translation buffer that holds memory replies until the miss queue takes them
`timescale 1ns/1ps
`include "ptw_consts.svh"

module ptw_tran_buf (
	input logic clk,
	input logic rst,
	input logic mem_rvalid,
	input logic [`PTW_QE_W-1:0] mem_rtag,
	input logic [31:0] mem_rdata,
	tran_if.source trn,
	output logic [`PTW_BFREE_W-1:0] buf_free
);

	localparam int SLOT_W = $clog2(`PTW_TRANBUF_SIZE);

	ptw_pkg::tranbuf_entry_t slot [`PTW_TRANBUF_SIZE];

	logic sel_v;
	logic [SLOT_W-1:0] sel_slot;
	logic wr_v;
	logic [SLOT_W-1:0] wr_slot;

	// ==================================================
	// Slot search
	// ==================================================

	// Scan downwards so the lowest full and lowest free slots win
	always_comb begin
		sel_v = 1'b0;
		sel_slot = '0;
		wr_v = 1'b0;
		wr_slot = '0;
		buf_free = '0;
		for (int i = `PTW_TRANBUF_SIZE - 1; i >= 0; i--) begin
			if (slot[i].v) begin
				sel_v = 1'b1;
				sel_slot = SLOT_W'(i);
			end else begin
				wr_v = 1'b1;
				wr_slot = SLOT_W'(i);
				buf_free = buf_free + `PTW_BFREE_W'(1);
			end
		end
	end

	assign trn.sel_v = sel_v;
	assign trn.stk = slot[sel_slot].stk;
	assign trn.pte = slot[sel_slot].pte;

	// ==================================================
	// Slot update
	// ==================================================

	// The write goes to a slot that is empty now, so it never meets the one being freed
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `PTW_TRANBUF_SIZE; i++)
				slot[i].v <= 1'b0;
		end else begin
			if (trn.take && sel_v)
				slot[sel_slot].v <= 1'b0;
			if (mem_rvalid && wr_v) begin
				slot[wr_slot] <= '{
					v: 1'b1,
					stk: mem_rtag,
					pte: ptw_pkg::pte_u'(mem_rdata)
				};
			end
		end
	end

endmodule

// ==== source/ptw_top.sv ====
// Top level of the page table walker with plain ports around the three blocks
`timescale 1ns/1ps
`include "ptw_consts.svh"

module ptw_top (
	input logic clk,
	input logic rst,
	input logic tlb_miss,
	input logic [31:0] tlb_miss_adr,
	input logic [`PTW_ASID_W-1:0] tlb_miss_asid,
	input logic [`PTW_ROB_W-1:0] tlb_miss_id,
	input logic [1:0] tlb_miss_qn,
	input logic [`PTW_ROB_W-1:0] commit0_id,
	input logic commit0_idv,
	input logic [`PTW_ROB_W-1:0] commit1_id,
	input logic commit1_idv,
	input logic flush_v,
	input logic [`PTW_ROB_W-1:0] flush_id,
	input logic [19:0] ptbr_frame,
	output logic mem_rd,
	output logic [`PTW_QE_W-1:0] mem_tag,
	output logic [31:0] mem_adr,
	input logic mem_rvalid,
	input logic [`PTW_QE_W-1:0] mem_rtag,
	input logic [31:0] mem_rdata,
	output logic tlb_wr,
	output logic [`PTW_ASID_W-1:0] tlb_asid,
	output logic [19:0] tlb_vpn,
	output logic [19:0] tlb_ppn,
	output logic [3:0] tlb_flags,
	output logic tlb_super,
	output logic tlb_fault,
	output logic in_que,
	output logic full
);

	// Free slot count from the buffer back to the walker
	logic [`PTW_BFREE_W-1:0] buf_free;

	walk_if walk ();
	tran_if trn ();

	// Holds the misses and finishes each walk
	ptw_miss_queue u_miss_queue (
		.clk(clk), .rst(rst),
		.tlb_miss(tlb_miss), .tlb_miss_adr(tlb_miss_adr), .tlb_miss_asid(tlb_miss_asid),
		.tlb_miss_id(tlb_miss_id), .tlb_miss_qn(tlb_miss_qn),
		.commit0_id(commit0_id), .commit0_idv(commit0_idv),
		.commit1_id(commit1_id), .commit1_idv(commit1_idv),
		.flush_v(flush_v), .flush_id(flush_id), .ptbr_frame(ptbr_frame),
		.walk(walk.source), .trn(trn.sink),
		.in_que(in_que), .full(full), .tlb_wr(tlb_wr), .tlb_asid(tlb_asid),
		.tlb_vpn(tlb_vpn), .tlb_ppn(tlb_ppn), .tlb_flags(tlb_flags),
		.tlb_super(tlb_super), .tlb_fault(tlb_fault)
	);

	// Sends table reads out to memory
	ptw_walker u_walker (
		.clk(clk), .rst(rst), .walk(walk.sink), .buf_free(buf_free),
		.mem_rvalid(mem_rvalid),
		.mem_rd(mem_rd), .mem_tag(mem_tag), .mem_adr(mem_adr)
	);

	// Parks the replies, which may come back out of order
	ptw_tran_buf u_tran_buf (
		.clk(clk), .rst(rst),
		.mem_rvalid(mem_rvalid), .mem_rtag(mem_rtag), .mem_rdata(mem_rdata),
		.trn(trn.source), .buf_free(buf_free)
	);

endmodule

// ==== tb/ptw_asserts.sv ====
// Bound protocol checks on the page table walker top level
`timescale 1ns/1ps
`include "ptw_consts.svh"

module ptw_asserts (
	input logic clk,
	input logic rst,
	input logic mem_rd,
	input logic mem_rvalid,
	input logic tlb_wr,
	input logic in_que
);

	// Reads seen on the port whose replies have not come back
	int unsigned rd_out;
	// Set once the first reset edge has cleared the output flops
	logic rst_seen = 1'b0;
	// Count of failed properties, watched by the testbench
	int unsigned fail_cnt = 0;

	always @(posedge clk) begin
		if (rst) begin
			rst_seen <= 1'b1;
			rd_out <= 0;
		end else begin
			rd_out <= rd_out + 32'(mem_rd) - 32'(mem_rvalid);
		end
	end

	// ==================================================
	// Properties
	// ==================================================

	// One read per queue entry at most, so a new read needs a spare entry
	rd_limit: assert property (@(posedge clk) disable iff (rst)
		mem_rd |-> rd_out < `PTW_MISSQ_SIZE)
		else begin
			$error("Memory read issued with %0d reads already in flight", rd_out);
			fail_cnt++;
		end

	rst_quiet: assert property (@(posedge clk) rst && rst_seen |-> !tlb_wr && !in_que)
		else begin
			$error("TLB write or in_que high during reset");
			fail_cnt++;
		end

	// A duplicate gives a single pulse
	inq_pulse: assert property (@(posedge clk) disable iff (rst) in_que |=> !in_que)
		else begin
			$error("in_que high for two cycles in a row");
			fail_cnt++;
		end

endmodule

bind ptw_top ptw_asserts u_asserts (
	.clk(clk), .rst(rst), .mem_rd(mem_rd), .mem_rvalid(mem_rvalid),
	.tlb_wr(tlb_wr), .in_que(in_que)
);

// ==== tb/ptw_tb.sv ====
// Testbench with clock, reset, page table memory model, stimulus, reference walk and compare
`timescale 1ns/1ps
`include "ptw_consts.svh"

module ptw_tb;

	localparam int SEED = 92970;
	localparam logic [19:0] PTBR = 20'h00100;
	localparam int N_MISS = 22;
	// Two reads of up to six cycles each plus queueing behind other walks
	localparam int WALK_CYC = 60;
	localparam int DRAIN_CYC = 20;

	typedef struct packed {
		logic [`PTW_ASID_W-1:0] asid;
		logic [19:0] vpn;
		logic [19:0] ppn;
		logic [3:0] flags;
		logic sup;
		logic fault;
	} exp_t;

	typedef struct packed {
		logic [`PTW_QE_W-1:0] tag;
		logic [31:0] data;
		int unsigned due;
	} rd_t;

	logic clk, rst, tlb_miss, commit0_idv, commit1_idv, flush_v;
	logic [31:0] tlb_miss_adr;
	logic [`PTW_ASID_W-1:0] tlb_miss_asid;
	logic [`PTW_ROB_W-1:0] tlb_miss_id, commit0_id, commit1_id, flush_id;
	logic [1:0] tlb_miss_qn;
	logic [19:0] ptbr_frame;
	logic mem_rd, mem_rvalid = 1'b0;
	logic [`PTW_QE_W-1:0] mem_tag, mem_rtag = '0;
	logic [31:0] mem_adr, mem_rdata = '0;
	logic tlb_wr, tlb_super, tlb_fault, in_que, full;
	logic [`PTW_ASID_W-1:0] tlb_asid;
	logic [19:0] tlb_vpn, tlb_ppn;
	logic [3:0] tlb_flags;

	// Page table words by byte address, plus per-read latencies drawn up front
	logic [31:0] pt [logic [31:0]];
	bit l1_used [1024];
	int lat_tab [64];
	rd_t pend [$];
	exp_t sb [$];
	int unsigned cyc = 0;
	int unsigned rd_n = 0;
	int unsigned inq_cnt = 0;
	logic [`PTW_ROB_W-1:0] id_n = '0;

	ptw_top dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1, "Run stopped at the first error");
	endtask

	// ==================================================
	// Page tables and reference walk
	// ==================================================

	// Words never written read as invalid, with the rest of the word taken from the address
	function automatic logic [31:0] read_table(input logic [31:0] adr);
		if (pt.exists(adr))
			return pt[adr];
		return {adr[31:1] ^ {adr[0], adr[31:2]}, 1'b0};
	endfunction

	// Kind 0 is a pointer chain, 1 a superpage, 2 invalid at level 1, 3 invalid at level 0
	task automatic make_tables(input int kind, output logic [31:0] adr);
		logic [9:0] i1;
		logic [9:0] i0;
		logic [19:0] frame;
		logic [31:0] w;
		i1 = 10'($urandom);
		while (l1_used[i1])
			i1 = 10'($urandom);
		l1_used[i1] = 1'b1;
		i0 = 10'($urandom);
		adr = {i1, i0, 12'($urandom)};
		// Each level 1 slot gets its own second table
		frame = 20'h80000 + 20'(i1);
		w = $urandom;
		case (kind)
			1: pt[{PTBR, i1, 2'b00}] = {w[31:2], 2'b11};
			2: pt[{PTBR, i1, 2'b00}] = {w[31:1], 1'b0};
			default: begin
				pt[{PTBR, i1, 2'b00}] = {frame, w[11:2], 2'b01};
				w = $urandom;
				pt[{frame, i0, 2'b00}] = {w[31:1], kind != 3};
			end
		endcase
	endtask

	function automatic exp_t expected_walk(input logic [31:0] adr, input logic [7:0] asid);
		exp_t r;
		ptw_pkg::pte_u e;
		r = '{asid: asid, vpn: adr[31:12], ppn: '0, flags: '0, sup: 1'b0, fault: 1'b0};
		e = read_table({PTBR, adr[31:22], 2'b00});
		if (!e.ptr.v) begin
			r.fault = 1'b1;
		end else if (e.ptr.leaf) begin
			// 4 MiB page, so the low ten frame bits follow the address
			r.sup = 1'b1;
			r.ppn = {e.leaf.ppn[19:10], adr[21:12]};
			r.flags = e.leaf.flags;
		end else begin
			e = read_table({e.ptr.frame, adr[21:12], 2'b00});
			r.fault = !e.ptr.v;
			r.ppn = e.leaf.ppn;
			r.flags = e.leaf.flags;
		end
		return r;
	endfunction

	// ==================================================
	// Memory model, compare and monitors
	// ==================================================

	// Replies go out one per cycle, the first ready one in the list, so order follows latency
	always @(posedge clk) begin : memory
		int pick;
		pick = -1;
		cyc++;
		if (rst) begin
			pend.delete();
			mem_rvalid <= 1'b0;
		end else begin
			if (mem_rd) begin
				pend.push_back('{tag: mem_tag, data: read_table(mem_adr),
					due: cyc + lat_tab[rd_n % 64]});
				rd_n++;
			end
			foreach (pend[i])
				if (pick < 0 && pend[i].due <= cyc)
					pick = i;
			mem_rvalid <= (pick >= 0);
			if (pick >= 0) begin
				mem_rtag <= pend[pick].tag;
				mem_rdata <= pend[pick].data;
				pend.delete(pick);
			end
		end
	end

	always @(negedge clk) begin : compare
		int idx;
		exp_t e;
		idx = -1;
		if (!rst && (tlb_wr || tlb_fault)) begin
			assert (!(tlb_wr && tlb_fault))
				else stop_on_error("TLB write and fault strobes high together");
			foreach (sb[i])
				if (idx < 0 && sb[i].asid == tlb_asid && sb[i].vpn == tlb_vpn)
					idx = i;
			assert (idx >= 0) else stop_on_error($sformatf(
				"TLB update for asid %h vpn %h that no walk expects", tlb_asid, tlb_vpn));
			e = sb[idx];
			assert (tlb_fault == e.fault) else stop_on_error($sformatf(
				"Mismatch tlb_fault got %h expected %h", tlb_fault, e.fault));
			if (!e.fault) begin
				assert (tlb_ppn == e.ppn) else stop_on_error($sformatf(
					"Mismatch tlb_ppn got %h expected %h", tlb_ppn, e.ppn));
				assert (tlb_flags == e.flags) else stop_on_error($sformatf(
					"Mismatch tlb_flags got %h expected %h", tlb_flags, e.flags));
				assert (tlb_super == e.sup) else stop_on_error($sformatf(
					"Mismatch tlb_super got %h expected %h", tlb_super, e.sup));
			end
			sb.delete(idx);
		end
	end

	always @(negedge clk) begin
		if (!rst && in_que)
			inq_cnt++;
		assert (dut_i.u_asserts.fail_cnt == 0)
			else stop_on_error("A protocol assertion on the DUT failed");
	end

	initial begin : watchdog
		repeat (N_MISS * WALK_CYC) @(posedge clk);
		stop_on_error("Watchdog expired before the tests finished");
	end

	// ==================================================
	// Stimulus tasks
	// ==================================================

	function automatic logic [`PTW_ROB_W-1:0] next_id();
		id_n = id_n + 1'b1;
		return id_n;
	endfunction

	// A miss may carry its own commit on slot 1 in the same cycle
	task automatic send_miss(input logic [31:0] adr, input logic [7:0] asid,
		input logic [`PTW_ROB_W-1:0] id, input logic cm);
		@(posedge clk);
		tlb_miss <= 1'b1;
		tlb_miss_adr <= adr;
		tlb_miss_asid <= asid;
		tlb_miss_id <= id;
		tlb_miss_qn <= id[1:0];
		commit1_idv <= cm;
		commit1_id <= id;
		@(posedge clk);
		tlb_miss <= 1'b0;
		commit1_idv <= 1'b0;
	endtask

	task automatic commit_two(input logic [`PTW_ROB_W-1:0] ida, input logic [`PTW_ROB_W-1:0] idb,
		input logic both);
		@(posedge clk);
		commit0_idv <= 1'b1;
		commit0_id <= ida;
		commit1_idv <= both;
		commit1_id <= idb;
		@(posedge clk);
		commit0_idv <= 1'b0;
		commit1_idv <= 1'b0;
	endtask

	task automatic flush_miss(input logic [`PTW_ROB_W-1:0] id);
		@(posedge clk);
		flush_v <= 1'b1;
		flush_id <= id;
		@(posedge clk);
		flush_v <= 1'b0;
	endtask

	// Expected writes done and memory idle, then room for a late reply to surface
	task automatic wait_quiet();
		do
			@(negedge clk);
		while (sb.size() != 0 || pend.size() != 0 || mem_rd);
		repeat (DRAIN_CYC) @(negedge clk);
	endtask

	// ==================================================
	// Test sequence
	// ==================================================

	initial begin : stimulus
		logic [31:0] a;
		logic [7:0] s;
		logic [`PTW_ROB_W-1:0] id;
		logic [`PTW_ROB_W-1:0] ids [5];
		int unsigned n0;
		void'($urandom(SEED));
		foreach (lat_tab[i])
			lat_tab[i] = 1 + int'($urandom % 6);
		rst = 1'b1;
		tlb_miss = 1'b0;
		tlb_miss_adr = '0;
		tlb_miss_asid = '0;
		tlb_miss_id = '0;
		tlb_miss_qn = '0;
		commit0_idv = 1'b0;
		commit0_id = '0;
		commit1_idv = 1'b0;
		commit1_id = '0;
		flush_v = 1'b0;
		flush_id = '0;
		ptbr_frame = PTBR;
		repeat (4) @(posedge clk);
		rst <= 1'b0;

		// Pointer chain, then superpage, invalid at level 1 and invalid at level 0
		for (int k = 0; k < 4; k++) begin
			make_tables(k, a);
			s = 8'($urandom);
			id = next_id();
			sb.push_back(expected_walk(a, s));
			send_miss(a, s, id, 1'b0);
			commit_two(id, id, 1'b0);
			wait_quiet();
		end

		// Same asid and address twice, and both ids commit so a captured copy would walk
		make_tables(0, a);
		s = 8'($urandom);
		ids[0] = next_id();
		ids[1] = next_id();
		n0 = inq_cnt;
		sb.push_back(expected_walk(a, s));
		send_miss(a, s, ids[0], 1'b0);
		send_miss(a, s, ids[1], 1'b0);
		commit_two(ids[0], ids[1], 1'b1);
		wait_quiet();
		assert (inq_cnt == n0 + 1) else stop_on_error($sformatf(
			"Mismatch in_que pulses got %h expected %h", inq_cnt - n0, 1));

		// Flushed before commit, so a later commit of the same id finds nothing
		make_tables(0, a);
		id = next_id();
		send_miss(a, 8'($urandom), id, 1'b0);
		flush_miss(id);
		commit_two(id, id, 1'b0);
		wait_quiet();

		// Flushed while its first read is out
		make_tables(0, a);
		s = 8'($urandom);
		id = next_id();
		send_miss(a, s, id, 1'b1);
		do
			@(negedge clk);
		while (!mem_rd);
		flush_miss(id);
		wait_quiet();
		// With the entry freed the same miss is taken again as a new walk
		n0 = inq_cnt;
		id = next_id();
		sb.push_back(expected_walk(a, s));
		send_miss(a, s, id, 1'b1);
		repeat (2) @(negedge clk);
		assert (inq_cnt == n0)
			else stop_on_error("Flushed entry was still live when its miss came again");
		wait_quiet();

		// Four walks at once, and a fifth miss that meets a full queue
		for (int k = 0; k < 4; k++) begin
			make_tables(k, a);
			s = 8'($urandom);
			ids[k] = next_id();
			sb.push_back(expected_walk(a, s));
			send_miss(a, s, ids[k], 1'b0);
		end
		@(negedge clk);
		assert (full) else stop_on_error("Queue did not report full after four misses");
		make_tables(0, a);
		ids[4] = next_id();
		send_miss(a, 8'($urandom), ids[4], 1'b0);
		commit_two(ids[0], ids[1], 1'b1);
		commit_two(ids[2], ids[3], 1'b1);
		wait_quiet();
		// A captured fifth miss would now walk and write
		commit_two(ids[4], ids[4], 1'b0);
		wait_quiet();

		// Random kinds, each committed with its miss
		for (int k = 0; k < 8; k++) begin
			make_tables(int'($urandom % 4), a);
			s = 8'($urandom);
			id = next_id();
			sb.push_back(expected_walk(a, s));
			@(negedge clk);
			while (full)
				@(negedge clk);
			send_miss(a, s, id, 1'b1);
		end
		wait_quiet();

		if (sb.size() == 0) begin
			$display("Simulation PASSED");
			$finish;
		end else begin
			stop_on_error($sformatf("%0d expected TLB updates never arrived", sb.size()));
		end
	end

endmodule

// ==== flist.f ====
+incdir+include
source/ptw_pkg.sv
source/ptw_if.sv
source/ptw_miss_queue.sv
source/ptw_walker.sv
source/ptw_tran_buf.sv
source/ptw_top.sv
tb/ptw_asserts.sv
tb/ptw_tb.sv

// ==== Bender.yml ====
package:
  name: ptw

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/ptw_pkg.sv
      - source/ptw_if.sv
      - source/ptw_miss_queue.sv
      - source/ptw_walker.sv
      - source/ptw_tran_buf.sv
      - source/ptw_top.sv
      - target: test
        files:
          - tb/ptw_asserts.sv
          - tb/ptw_tb.sv
